// ==== Makefile ====
# Verilator build and run of the cart_ascii8 testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_cart_ascii8
FILELIST  ?= cart_ascii8.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cart_ascii8.f ====
msx_mapper_pkg.sv
mapper_decode.sv
mapper_bank_regs.sv
mapper_addr_gen.sv
cart_ascii8.sv
cart_ascii8_asserts.sv
tb_cart_ascii8.sv

// ==== cart_ascii8.sv ====
// ASCII8 mapper with battery SRAM for two cartridge slots, A (slot low) and B (slot high)
// Port reset is the clock and port clk is the asynchronous active-high reset
// Register writes take effect on the next clock edge; reads are combinational

`timescale 1ns/1ps

module cart_ascii8
    import msx_mapper_pkg::*;
(
    input  logic      reset,
    input  logic      clk,
    input  rom_size_t rom_size,
    input  cpu_addr_t addr,
    input  cpu_data_t d_from_cpu,
    input  logic      wr,
    input  logic      cs,
    input  logic      slot,
    input  logic      koei,
    input  logic      wizardry,
    output mem_addr_t mem_addr,
    output logic      sram_we,
    output logic      sram_oe
);

    logic    reg_wr_a;
    logic    reg_wr_b;
    logic    is_sram_sel;
    region_t region;
    page_t   read_page;

    bank_t   rom_bank_a;
    bank_t   rom_bank_b;
    bank_t   sram_bank_a;
    bank_t   sram_bank_b;
    logic    sram_en_a;
    logic    sram_en_b;

    mapper_decode decode_inst (
        .addr        (addr),
        .d_from_cpu  (d_from_cpu),
        .cs          (cs),
        .wr          (wr),
        .slot        (slot),
        .wizardry    (wizardry),
        .rom_size    (rom_size),
        .reg_wr_a    (reg_wr_a),
        .reg_wr_b    (reg_wr_b),
        .is_sram_sel (is_sram_sel),
        .region      (region),
        .read_page   (read_page)
    );

    // Both slots look up the same page, the address generator picks one
    mapper_bank_regs bank_regs_a (
        .reset       (reset),
        .clk         (clk),
        .reg_wr      (reg_wr_a),
        .is_sram_sel (is_sram_sel),
        .region      (region),
        .read_page   (read_page),
        .d_from_cpu  (d_from_cpu),
        .koei        (koei),
        .rom_size    (rom_size),
        .rom_bank    (rom_bank_a),
        .sram_bank   (sram_bank_a),
        .sram_en     (sram_en_a)
    );

    mapper_bank_regs bank_regs_b (
        .reset       (reset),
        .clk         (clk),
        .reg_wr      (reg_wr_b),
        .is_sram_sel (is_sram_sel),
        .region      (region),
        .read_page   (read_page),
        .d_from_cpu  (d_from_cpu),
        .koei        (koei),
        .rom_size    (rom_size),
        .rom_bank    (rom_bank_b),
        .sram_bank   (sram_bank_b),
        .sram_en     (sram_en_b)
    );

    mapper_addr_gen addr_gen_inst (
        .addr        (addr),
        .cs          (cs),
        .wr          (wr),
        .slot        (slot),
        .rom_bank_a  (rom_bank_a),
        .rom_bank_b  (rom_bank_b),
        .sram_bank_a (sram_bank_a),
        .sram_bank_b (sram_bank_b),
        .sram_en_a   (sram_en_a),
        .sram_en_b   (sram_en_b),
        .mem_addr    (mem_addr),
        .sram_oe     (sram_oe),
        .sram_we     (sram_we)
    );

endmodule

// ==== cart_ascii8_asserts.sv ====
// SRAM strobe rules for cart_ascii8, sampled on the clock port named reset
// The port named clk is the asynchronous active-high reset

`timescale 1ns/1ps

module cart_ascii8_asserts (
    input logic reset,
    input logic clk,
    input logic cs,
    input logic sram_oe,
    input logic sram_we
);

    // A write strobe without an output enable would hit an unmapped SRAM
    we_needs_oe: assert property (@(posedge reset) disable iff (clk) sram_we |-> sram_oe)
        else $error("sram_we is high while sram_oe is low");

    oe_needs_cs: assert property (@(posedge reset) disable iff (clk) sram_oe |-> cs)
        else $error("sram_oe is high without cs");

    // The enable mask is cleared during reset, so no page can map SRAM
    oe_low_in_reset: assert property (@(posedge reset) clk |-> !sram_oe)
        else $error("sram_oe is high during reset");

endmodule

bind cart_ascii8 cart_ascii8_asserts asserts_inst (
    .reset   (reset),
    .clk     (clk),
    .cs      (cs),
    .sram_oe (sram_oe),
    .sram_we (sram_we)
);

// ==== mapper_addr_gen.sv ====
// Slot select and memory address formation
// Output is purely combinational from the bus and the bank register outputs
// Only the low two SRAM bank bits reach mem_addr, so SRAM is at most 32 kB

`timescale 1ns/1ps

module mapper_addr_gen
    import msx_mapper_pkg::*;
(
    input  cpu_addr_t addr,
    input  logic      cs,
    input  logic      wr,
    input  logic      slot,
    input  bank_t     rom_bank_a,
    input  bank_t     rom_bank_b,
    input  bank_t     sram_bank_a,
    input  bank_t     sram_bank_b,
    input  logic      sram_en_a,
    input  logic      sram_en_b,
    output mem_addr_t mem_addr,
    output logic      sram_oe,
    output logic      sram_we
);

    bank_t                     rom_bank_sel;
    bank_t                     sram_bank_sel;
    logic                      sram_en_sel;
    logic [PAGE_OFFSET_W-1:0]  page_offset;
    logic [SRAM_BANK_W-1:0]    sram_bank_low;
    mem_addr_t                 rom_addr;
    mem_addr_t                 sram_addr;

    // Slot B is active when slot is high
    always_comb begin
        if (slot) begin
            rom_bank_sel  = rom_bank_b;
            sram_bank_sel = sram_bank_b;
            sram_en_sel   = sram_en_b;
        end else begin
            rom_bank_sel  = rom_bank_a;
            sram_bank_sel = sram_bank_a;
            sram_en_sel   = sram_en_a;
        end
    end

    assign page_offset   = addr[PAGE_OFFSET_W-1:0];
    assign sram_bank_low = sram_bank_sel[SRAM_BANK_W-1:0];

    // SRAM strobes only for a selected cartridge and an enabled page
    assign sram_oe = cs & sram_en_sel;
    assign sram_we = sram_oe & wr;

    // Both addresses are zero-extended to the full memory width
    assign rom_addr  = mem_addr_t'({rom_bank_sel, page_offset});
    assign sram_addr = mem_addr_t'({sram_bank_low, page_offset});

    assign mem_addr = sram_oe ? sram_addr : rom_addr;

endmodule

// ==== mapper_bank_regs.sv ====
// Mapper register bank for one cartridge slot
// Port reset is the clock and port clk is the asynchronous active-high reset
// Bank numbers are indexed by region; page p maps to region (p - 2) mod 4

`timescale 1ns/1ps

module mapper_bank_regs
    import msx_mapper_pkg::*;
(
    input  logic      reset,
    input  logic      clk,
    input  logic      reg_wr,
    input  logic      is_sram_sel,
    input  region_t   region,
    input  page_t     read_page,
    input  cpu_data_t d_from_cpu,
    input  logic      koei,
    input  rom_size_t rom_size,
    output bank_t     rom_bank,
    output bank_t     sram_bank,
    output logic      sram_en
);

    bank_t   rom_banks [4];
    bank_t   sram_banks [4];

    // One bit per 8 kB CPU page, set where SRAM is mapped
    bank_t   sram_en_mask;

    bank_t   rom_bank_count;
    bank_t   rom_bank_mask;
    bank_t   allowed_pages;
    page_t   wr_page;
    bank_t   wr_page_bit;
    page_t   read_offset;
    region_t read_region;

    // Number of 8 kB banks in the ROM, also used as the SRAM bank mask
    assign rom_bank_count = rom_size[20:13];
    assign rom_bank_mask  = rom_bank_count - 8'd1;

    // Koei carts additionally allow SRAM in page 2
    assign allowed_pages = koei ? SRAM_PAGES_KOEI : SRAM_PAGES_ASCII8;

    // The page served by the written region
    assign wr_page     = FIRST_BANK_PAGE + page_t'(region);
    assign wr_page_bit = bank_t'(1) << wr_page;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < 4; i++) begin
                rom_banks[i]  <= '0;
                sram_banks[i] <= '0;
            end
            sram_en_mask <= '0;
        end else if (reg_wr) begin
            if (is_sram_sel) begin
                // Map SRAM in, but never outside the pages the mode allows
                sram_en_mask       <= sram_en_mask | (wr_page_bit & allowed_pages);
                sram_banks[region] <= d_from_cpu & rom_bank_count;
            end else begin
                // A ROM bank write always unmaps SRAM from that page
                sram_en_mask      <= sram_en_mask & ~wr_page_bit;
                rom_banks[region] <= d_from_cpu;
            end
        end
    end

    // Pages 0, 1, 6 and 7 wrap onto regions 2, 3, 0 and 1 like the
    // mirrored banks on real hardware
    assign read_offset = read_page - FIRST_BANK_PAGE;
    assign read_region = read_offset[1:0];

    assign rom_bank  = rom_banks[read_region] & rom_bank_mask;

    // SRAM banks are stored already masked
    assign sram_bank = sram_banks[read_region];

    assign sram_en   = sram_en_mask[read_page];

endmodule

// ==== mapper_decode.sv ====
// Shared CPU bus decode for both cartridge slots
// The write strobes are already split by slot, so only one bank register block sees a write
// rom_size must be a power of two, its bits [20:13] give the SRAM select bit

`timescale 1ns/1ps

module mapper_decode
    import msx_mapper_pkg::*;
(
    input  cpu_addr_t addr,
    input  cpu_data_t d_from_cpu,
    input  logic      cs,
    input  logic      wr,
    input  logic      slot,
    input  logic      wizardry,
    input  rom_size_t rom_size,
    output logic      reg_wr_a,
    output logic      reg_wr_b,
    output logic      is_sram_sel,
    output region_t   region,
    output page_t     read_page
);

    page_t cpu_page;
    logic  in_reg_window;
    logic  reg_wr;
    bank_t sram_sel_bit;

    // Page of the current access, used both for the write window and the lookup
    assign cpu_page = addr[15:13];

    assign in_reg_window = (cpu_page == REG_WINDOW_PAGE);

    // A register write is a single cycle with cs and wr high inside the window
    assign reg_wr = cs & wr & in_reg_window;

    // Slot A is selected when slot is low
    assign reg_wr_a = reg_wr & ~slot;
    assign reg_wr_b = reg_wr & slot;

    // The bit that marks a write as an SRAM select.
    // Outside wizardry mode it is the bank number one past the ROM,
    // which is rom_size / 8 kB
    always_comb begin
        if (wizardry) begin
            sram_sel_bit = WIZARDRY_SRAM_BIT;
        end else begin
            sram_sel_bit = rom_size[20:13];
        end
    end

    assign is_sram_sel = |(d_from_cpu & sram_sel_bit);

    // Each 2 kB slice of the window addresses one region
    assign region = addr[12:11];

    // The read page is forwarded unchanged, bank_regs does the region mapping
    assign read_page = cpu_page;

endmodule

// ==== msx_mapper_pkg.sv ====
// Shared widths and constants for the ASCII8/Koei/Wizardry bank mapper
// Page and region numbering assume the standard 8 kB MSX page layout

package msx_mapper_pkg;

    // Cartridge ROM size in bytes, must be a power of two from 16 kB up
    typedef logic [24:0] rom_size_t;

    // CPU side of the bus
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // Translated address into the ROM or SRAM image
    typedef logic [24:0] mem_addr_t;

    // Bank numbers and the per-page SRAM enable mask share this width
    typedef logic [7:0]  bank_t;

    // Register region selected by addr[12:11]
    typedef logic [1:0]  region_t;

    // 8 kB CPU page selected by addr[15:13]
    typedef logic [2:0]  page_t;

    // Address bits inside one 8 kB page
    localparam int PAGE_OFFSET_W = 13;

    // Only the low bank bits reach the SRAM address
    localparam int SRAM_BANK_W = 2;

    // Writes to 0x6000-0x7FFF land in the mapper registers
    localparam page_t REG_WINDOW_PAGE = 3'd3;

    // Page 2 (0x4000) is served by region 0
    localparam page_t FIRST_BANK_PAGE = 3'd2;

    // SRAM may only appear in pages 4 and 5 for plain ASCII8
    localparam bank_t SRAM_PAGES_ASCII8 = 8'h30;

    // Koei carts also allow SRAM at page 2
    localparam bank_t SRAM_PAGES_KOEI = 8'h34;

    // Wizardry uses a fixed SRAM select bit instead of one derived from rom_size
    localparam bank_t WIZARDRY_SRAM_BIT = 8'h80;

endpackage

// ==== tb_cart_ascii8.sv ====
// Self-checking testbench for the two-slot ASCII8 mapper
// The signal named reset is the clock and clk is the asynchronous active-high reset
// Inputs change 2 ns after the rising edge, outputs are checked 3 ns before the next one

`timescale 1ns/1ps

module tb_cart_ascii8
    import msx_mapper_pkg::*;
;

    localparam int HALF_PERIOD  = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int CHECK_DELAY  = 35;

    // Cycle budget of each test, used for the watchdog limit
    localparam int RESET_CYCLES = 3;
    localparam int ROM_ITERS    = 30;
    localparam int WE_CYCLES    = 60;
    localparam int WIZ_ITERS    = 30;
    localparam int ISO_ITERS    = 8;
    localparam int T1_CYCLES    = 16;
    localparam int T2_CYCLES    = ROM_ITERS * 8;
    localparam int T3_CYCLES    = 2 * 2 * 16;
    localparam int T4_CYCLES    = 6 + WE_CYCLES;
    localparam int T5_CYCLES    = WIZ_ITERS * 5;
    localparam int T6_CYCLES    = ISO_ITERS * 2 * 8;
    localparam int MAX_CYCLES   = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES + T6_CYCLES + 50;

    logic      reset;
    logic      clk;
    rom_size_t rom_size;
    cpu_addr_t addr;
    cpu_data_t d_from_cpu;
    logic      wr;
    logic      cs;
    logic      slot;
    logic      koei;
    logic      wizardry;
    mem_addr_t mem_addr;
    logic      sram_we;
    logic      sram_oe;

    // Reference model, one row per slot
    bank_t     rom_m [2][4];
    bank_t     sram_m [2][4];
    bank_t     en_m [2];

    int        error_count;
    int        check_count;
    int        test_errors;
    int        test_checks;
    int        cycle_count;

    cart_ascii8 cart_ascii8_inst (
        .reset      (reset),
        .clk        (clk),
        .rom_size   (rom_size),
        .addr       (addr),
        .d_from_cpu (d_from_cpu),
        .wr         (wr),
        .cs         (cs),
        .slot       (slot),
        .koei       (koei),
        .wizardry   (wizardry),
        .mem_addr   (mem_addr),
        .sram_we    (sram_we),
        .sram_oe    (sram_oe)
    );

    initial begin
        reset = 1'b0;
        forever #(HALF_PERIOD) reset = ~reset;
    end

    // Page 2 is served by region 0, the others follow modulo four
    function automatic region_t page_region(page_t p);
        page_t off;
        off = p - 3'd2;
        return off[1:0];
    endfunction

    function automatic mem_addr_t predict_addr(logic s, cpu_addr_t a, logic c, rom_size_t rs);
        page_t   p;
        region_t r;
        bank_t   mask;
        p    = a[15:13];
        r    = page_region(p);
        mask = rs[20:13] - 8'd1;
        if (c && en_m[s][p]) begin
            return {10'd0, sram_m[s][r][1:0], a[12:0]};
        end
        return {4'd0, rom_m[s][r] & mask, a[12:0]};
    endfunction

    function automatic rom_size_t random_rom_size(int lo_exp, int hi_exp);
        int e;
        e = int'($urandom_range(hi_exp, lo_exp));
        return rom_size_t'(1) << e;
    endfunction

    // Applies one register write to the model with the current mode inputs
    task automatic model_write(logic s, region_t r, cpu_data_t d);
        bank_t count;
        bank_t sel_bit;
        bank_t allowed;
        bank_t page_bit;
        page_t p;
        count    = rom_size[20:13];
        sel_bit  = wizardry ? WIZARDRY_SRAM_BIT : count;
        allowed  = koei ? SRAM_PAGES_KOEI : SRAM_PAGES_ASCII8;
        p        = 3'd2 + page_t'(r);
        page_bit = 8'd1 << p;
        if ((d & sel_bit) != 8'd0) begin
            en_m[s]      = en_m[s] | (page_bit & allowed);
            sram_m[s][r] = d & count;
        end else begin
            en_m[s]     = en_m[s] & ~page_bit;
            rom_m[s][r] = d;
        end
    endtask

    task automatic report_mismatch(string name, logic [24:0] exp_val, logic [24:0] got_val);
        $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_val, got_val);
        error_count++;
        test_errors++;
    endtask

    task automatic check_outputs;
        mem_addr_t exp_addr;
        logic      exp_oe;
        logic      exp_we;
        exp_addr = predict_addr(slot, addr, cs, rom_size);
        exp_oe   = cs & en_m[slot][addr[15:13]];
        exp_we   = exp_oe & wr;
        check_count++;
        test_checks++;
        if (mem_addr !== exp_addr) begin
            report_mismatch("mem_addr", exp_addr, mem_addr);
        end
        if (sram_oe !== exp_oe) begin
            report_mismatch("sram_oe", 25'(exp_oe), 25'(sram_oe));
        end
        if (sram_we !== exp_we) begin
            report_mismatch("sram_we", 25'(exp_we), 25'(sram_we));
        end
    endtask

    task automatic next_cycle;
        @(posedge reset);
        #(DRIVE_DELAY);
    endtask

    // Each bus cycle starts 2 ns after an edge and ends 2 ns after the next one.
    // The write cycle is checked against the old state, the model moves on afterwards
    task automatic cpu_write(logic s, region_t r, cpu_data_t d);
        slot       = s;
        cs         = 1'b1;
        wr         = 1'b1;
        addr       = {3'd3, r, 11'($urandom)};
        d_from_cpu = d;
        #(CHECK_DELAY);
        check_outputs();
        model_write(s, r, d);
        next_cycle();
    endtask

    task automatic cpu_read(logic s, page_t p, logic c, logic w);
        slot       = s;
        cs         = c;
        wr         = w;
        addr       = {p, 13'($urandom)};
        d_from_cpu = 8'($urandom);
        #(CHECK_DELAY);
        check_outputs();
        next_cycle();
    endtask

    task automatic read_bank_pages(logic s);
        for (int p = 2; p < 6; p++) begin
            cpu_read(s, page_t'(p), 1'b1, 1'b0);
        end
    endtask

    task automatic begin_test;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test(string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge reset);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        cpu_data_t d;
        logic      s;
        logic      c;
        logic      w;
        page_t     p;

        void'($urandom(32'h917d));
        clk         = 1'b1;
        rom_size    = rom_size_t'(1) << 17;
        addr        = '0;
        d_from_cpu  = '0;
        wr          = 1'b0;
        cs          = 1'b0;
        slot        = 1'b0;
        koei        = 1'b0;
        wizardry    = 1'b0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < 2; i++) begin
            en_m[i] = '0;
            for (int j = 0; j < 4; j++) begin
                rom_m[i][j]  = '0;
                sram_m[i][j] = '0;
            end
        end

        repeat (RESET_CYCLES) @(posedge reset);
        #(DRIVE_DELAY);
        clk = 1'b0;

        // Every page reads bank 0 right after reset
        begin_test();
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 8; j++) begin
                cpu_read(i[0], page_t'(j), 1'b1, 1'b0);
            end
        end
        finish_test("reset_reads");

        begin_test();
        for (int it = 0; it < ROM_ITERS; it++) begin
            rom_size = random_rom_size(14, 21);
            s        = 1'($urandom);
            for (int r = 0; r < 4; r++) begin
                d = 8'($urandom) & ~rom_size[20:13];
                cpu_write(s, region_t'(r), d);
            end
            read_bank_pages(s);
        end
        finish_test("rom_banks");

        // SRAM in, then ROM writes to the same regions take it out again
        begin_test();
        for (int k = 0; k < 2; k++) begin
            koei = k[0];
            for (int i = 0; i < 2; i++) begin
                rom_size = random_rom_size(14, 20);
                for (int r = 0; r < 4; r++) begin
                    cpu_write(i[0], region_t'(r), 8'($urandom) | rom_size[20:13]);
                end
                read_bank_pages(i[0]);
                for (int r = 0; r < 4; r++) begin
                    cpu_write(i[0], region_t'(r), 8'($urandom) & ~rom_size[20:13]);
                end
                read_bank_pages(i[0]);
            end
        end
        finish_test("sram_select");

        begin_test();
        koei     = 1'b1;
        rom_size = random_rom_size(14, 20);
        for (int i = 0; i < 2; i++) begin
            cpu_write(i[0], 2'd0, rom_size[20:13]);
            cpu_write(i[0], 2'd2, rom_size[20:13] | 8'($urandom));
            cpu_write(i[0], 2'd3, rom_size[20:13]);
        end
        for (int n = 0; n < WE_CYCLES; n++) begin
            s = 1'($urandom);
            p = 3'($urandom);
            c = 1'($urandom);
            w = 1'($urandom);
            // A write into page 3 would land in the registers
            if (p == 3'd3) begin
                w = 1'b0;
            end
            cpu_read(s, p, c, w);
        end
        finish_test("sram_we");

        begin_test();
        wizardry = 1'b1;
        for (int it = 0; it < WIZ_ITERS; it++) begin
            koei     = 1'($urandom);
            rom_size = random_rom_size(14, 21);
            s        = 1'($urandom);
            cpu_write(s, 2'($urandom), 8'($urandom));
            read_bank_pages(s);
        end
        wizardry = 1'b0;
        finish_test("wizardry");

        begin_test();
        for (int it = 0; it < ISO_ITERS; it++) begin
            koei     = 1'($urandom);
            rom_size = random_rom_size(14, 20);
            for (int i = 0; i < 2; i++) begin
                for (int r = 0; r < 4; r++) begin
                    cpu_write(i[0], region_t'(r), 8'($urandom));
                end
                read_bank_pages(~i[0]);
            end
        end
        finish_test("slot_isolation");

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
